/* src.f */
rtl/rv32_isa_pkg.sv
rtl/exec_pkg.sv
rtl/register_file.sv
rtl/alu.sv
rtl/instr_decoder.sv
rtl/writeback_stage.sv
rtl/exec_unit_top.sv
tests/exec_unit_props.sv
tests/exec_unit_tb.sv

/* tests/exec_unit_tb.sv */
module exec_unit_tb
        import rv32_isa_pkg::*;
        import exec_pkg::*;
();

        typedef struct packed {
                logic        illegal;
                reg_idx_t    rd;
                data_t       data;
                logic [31:0] cycle;
        } expect_t;

        logic     clk;
        logic     reset;
        logic     instr_valid;
        instr_t   instr;
        logic     wb_valid;
        logic     wb_illegal;
        reg_idx_t wb_rd;
        data_t    wb_data;
        logic     wb_zero;

        data_t       model_regs [0:NUM_REGS-1];
        expect_t     pending [$];
        logic [31:0] cycle_count;
        integer      seed;
        int          assertion_failures;

        exec_unit_top exec_unit_top_inst (
                .clk         (clk),
                .reset       (reset),
                .instr_valid (instr_valid),
                .instr       (instr),
                .wb_valid    (wb_valid),
                .wb_illegal  (wb_illegal),
                .wb_rd       (wb_rd),
                .wb_data     (wb_data),
                .wb_zero     (wb_zero)
        );

        assign assertion_failures =
                exec_unit_top_inst.writeback_stage_inst.exec_unit_props_inst.failures;

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        task automatic fail_run(input string why);
                $display("%s", why);
                $display("TEST FAIL");
                $fatal(1);
        endtask

        task automatic check_value(input string name, input data_t actual, input data_t expected);
                if (actual !== expected)
                        fail_run($sformatf("mismatch %s: actual 0x%h expected 0x%h",
                                name, actual, expected));
        endtask

        function automatic instr_t r_type_word(input funct7_t f7, input reg_idx_t rs2,
                                               input reg_idx_t rs1, input funct3_t f3,
                                               input reg_idx_t rd);
                return {f7, rs2, rs1, f3, rd, OPCODE_OP};
        endfunction

        function automatic instr_t i_type_word(input logic [11:0] imm, input reg_idx_t rs1,
                                               input funct3_t f3, input reg_idx_t rd);
                return {imm, rs1, f3, rd, OPCODE_OP_IMM};
        endfunction

        function automatic instr_t lui_word(input logic [19:0] imm, input reg_idx_t rd);
                return {imm, rd, OPCODE_LUI};
        endfunction

        // Reference model of the RV32I subset. It updates the model registers like the ISA does.
        task automatic model_exec(input instr_t w, output logic illegal, output data_t res);
                opcode_t opcode;
                funct3_t f3;
                funct7_t f7;
                data_t   a;
                data_t   b;
                logic    alt;
                opcode = w[6:0];
                f3     = w[14:12];
                f7     = w[31:25];
                alt    = (f7 == F7_ALT);
                a      = model_regs[w[19:15]];
                b      = (opcode == OPCODE_OP) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
                illegal = 1'b0;
                res     = '0;
                if (opcode == OPCODE_LUI) begin
                        res = {w[31:12], 12'h000};
                end else if ((opcode == OPCODE_OP) || (opcode == OPCODE_OP_IMM)) begin
                        case (f3)
                                F3_ADD_SUB: res = ((opcode == OPCODE_OP) && alt) ? a - b : a + b;
                                F3_SLL:     res = a << b[4:0];
                                F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                                F3_SLTU:    res = (a < b) ? 32'd1 : 32'd0;
                                F3_XOR:     res = a ^ b;
                                F3_SRL_SRA: res = alt ? data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                                F3_OR:      res = a | b;
                                default:    res = a & b;
                        endcase
                        if (opcode == OPCODE_OP)
                                illegal = !((f7 == F7_BASE) ||
                                        (alt && ((f3 == F3_ADD_SUB) || (f3 == F3_SRL_SRA))));
                        else if (f3 == F3_SLL)
                                illegal = (f7 != F7_BASE);
                        else if (f3 == F3_SRL_SRA)
                                illegal = !((f7 == F7_BASE) || alt);
                end else begin
                        illegal = 1'b1;
                end
                if (!illegal && (w[11:7] != '0))
                        model_regs[w[11:7]] = res;
        endtask

        // The result shows up at the third falling edge after the driving edge.
        task automatic send_instr(input instr_t w);
                expect_t e;
                @(posedge clk);
                instr       <= w;
                instr_valid <= 1'b1;
                model_exec(w, e.illegal, e.data);
                e.rd    = w[11:7];
                e.cycle = cycle_count + 3;
                pending.push_back(e);
        endtask

        task automatic stop_issue();
                @(posedge clk);
                instr_valid <= 1'b0;
        endtask

        task automatic drain_results();
                int waited;
                waited = 0;
                while ((pending.size() != 0) && (waited < 20)) begin
                        @(posedge clk);
                        waited++;
                end
                if (pending.size() != 0)
                        fail_run("timeout while waiting for a writeback result");
        endtask

        task automatic execute(input instr_t w);
                send_instr(w);
                stop_issue();
                drain_results();
        endtask

        // LUI plus ADDI, with the upper part rounded for the sign of the low twelve bits.
        task automatic load_reg(input reg_idx_t rd, input data_t value);
                logic [19:0] upper;
                upper = value[31:12] + {19'd0, value[11]};
                execute(lui_word(upper, rd));
                execute(i_type_word(value[11:0], rd, F3_ADD_SUB, rd));
        endtask

        initial begin
                expect_t e;
                cycle_count = '0;
                forever begin
                        @(negedge clk);
                        cycle_count++;
                        if (assertion_failures != 0)
                                fail_run("an assertion in the writeback stage failed");
                        if (wb_valid === 1'b1) begin
                                if (pending.size() == 0) begin
                                        fail_run("writeback seen with no instruction outstanding");
                                end else begin
                                        e = pending.pop_front();
                                        check_value("wb latency", cycle_count, e.cycle);
                                        check_value("wb_illegal", wb_illegal, e.illegal);
                                        check_value("wb_rd", wb_rd, e.rd);
                                        if (!e.illegal) begin
                                                check_value("wb_data", wb_data, e.data);
                                                check_value("wb_zero", wb_zero, e.data == '0);
                                        end
                                end
                        end
                end
        end

        task automatic immediates_and_lui();
                execute(i_type_word($random(seed), 5'd0, F3_ADD_SUB, 5'd1));
                execute(i_type_word(12'h800, 5'd0, F3_ADD_SUB, 5'd2));
                for (int r = 3; r < 9; r++) begin
                        load_reg(reg_idx_t'(r), $random(seed));
                end
                load_reg(5'd9, 32'hfedc_b987);
        endtask

        task automatic register_ops();
                load_reg(5'd3, 32'hffff_fff0);
                load_reg(5'd4, 32'h0000_0010);
                execute(r_type_word(F7_BASE, 5'd2, 5'd1, F3_ADD_SUB, 5'd10));
                execute(r_type_word(F7_ALT, 5'd5, 5'd6, F3_ADD_SUB, 5'd10));
                execute(r_type_word(F7_BASE, 5'd7, 5'd8, F3_AND, 5'd10));
                execute(r_type_word(F7_BASE, 5'd7, 5'd8, F3_OR, 5'd10));
                execute(r_type_word(F7_BASE, 5'd5, 5'd9, F3_XOR, 5'd10));
                execute(r_type_word(F7_BASE, 5'd4, 5'd3, F3_SLT, 5'd10));
                execute(r_type_word(F7_BASE, 5'd4, 5'd3, F3_SLTU, 5'd10));
                execute(r_type_word(F7_BASE, 5'd3, 5'd4, F3_SLT, 5'd10));
                execute(r_type_word(F7_BASE, 5'd3, 5'd4, F3_SLTU, 5'd10));
                execute(r_type_word(F7_ALT, 5'd1, 5'd1, F3_ADD_SUB, 5'd11));
                execute(i_type_word(12'hfff, 5'd4, F3_SLT, 5'd11));
                execute(i_type_word(12'hfff, 5'd4, F3_SLTU, 5'd11));
                execute(i_type_word($random(seed), 5'd5, F3_XOR, 5'd11));
                execute(i_type_word($random(seed), 5'd6, F3_OR, 5'd11));
                execute(i_type_word($random(seed), 5'd7, F3_AND, 5'd11));
        endtask

        task automatic shift_ops();
                load_reg(5'd5, 32'h8000_00f1);
                load_reg(5'd6, 32'd37);
                load_reg(5'd7, 32'd31);
                load_reg(5'd8, 32'd0);
                execute(r_type_word(F7_BASE, 5'd6, 5'd5, F3_SLL, 5'd12));
                execute(r_type_word(F7_BASE, 5'd6, 5'd5, F3_SRL_SRA, 5'd12));
                execute(r_type_word(F7_ALT, 5'd6, 5'd5, F3_SRL_SRA, 5'd12));
                execute(r_type_word(F7_ALT, 5'd7, 5'd5, F3_SRL_SRA, 5'd12));
                execute(r_type_word(F7_BASE, 5'd8, 5'd5, F3_SLL, 5'd12));
                execute(i_type_word({F7_BASE, 5'd0}, 5'd5, F3_SLL, 5'd12));
                execute(i_type_word({F7_BASE, 5'd31}, 5'd5, F3_SLL, 5'd12));
                execute(i_type_word({F7_BASE, 5'd31}, 5'd5, F3_SRL_SRA, 5'd12));
                execute(i_type_word({F7_ALT, 5'd31}, 5'd5, F3_SRL_SRA, 5'd12));
                execute(i_type_word({F7_ALT, 5'd4}, 5'd5, F3_SRL_SRA, 5'd12));
        endtask

        // Each instruction reads the result of the one issued the cycle before.
        task automatic dependent_chain();
                send_instr(i_type_word(12'h005, 5'd0, F3_ADD_SUB, 5'd13));
                send_instr(r_type_word(F7_BASE, 5'd13, 5'd13, F3_ADD_SUB, 5'd13));
                send_instr(r_type_word(F7_ALT, 5'd1, 5'd13, F3_ADD_SUB, 5'd14));
                send_instr(r_type_word(F7_BASE, 5'd13, 5'd14, F3_XOR, 5'd13));
                send_instr(i_type_word({F7_BASE, 5'd3}, 5'd14, F3_SLL, 5'd14));
                send_instr(r_type_word(F7_BASE, 5'd13, 5'd14, F3_SLTU, 5'd15));
                stop_issue();
                drain_results();
        endtask

        task automatic illegal_and_x0();
                execute({12'h001, 5'd1, 3'b000, 5'd1, 7'b0001011});
                execute(r_type_word(7'b0000001, 5'd2, 5'd1, F3_ADD_SUB, 5'd1));
                execute(i_type_word({F7_ALT, 5'd3}, 5'd2, F3_SLL, 5'd2));
                execute(i_type_word(12'h000, 5'd1, F3_ADD_SUB, 5'd16));
                execute(r_type_word(F7_BASE, 5'd0, 5'd2, F3_ADD_SUB, 5'd16));
                execute(i_type_word(12'h07b, 5'd1, F3_ADD_SUB, 5'd0));
                execute(r_type_word(F7_BASE, 5'd0, 5'd0, F3_ADD_SUB, 5'd16));
                send_instr(i_type_word(12'h005, 5'd1, F3_ADD_SUB, 5'd0));
                send_instr(r_type_word(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd17));
                stop_issue();
                drain_results();
        endtask

        initial begin
                seed        = 9;
                reset       = 1'b1;
                instr_valid = 1'b0;
                instr       = '0;
                for (int r = 0; r < NUM_REGS; r++) begin
                        model_regs[r] = '0;
                end
                repeat (3) @(posedge clk);
                reset <= 1'b0;
                immediates_and_lui();
                register_ops();
                shift_ops();
                dependent_chain();
                illegal_and_x0();
                repeat (2) @(posedge clk);
                @(negedge clk);
                if (assertion_failures != 0) begin
                        fail_run("an assertion in the writeback stage failed");
                end else begin
                        $display("TEST PASS");
                        $finish;
                end
        end

endmodule

/* tests/exec_unit_props.sv */
module exec_unit_props
        import exec_pkg::*;
(
        input logic        clk,
        input logic        reset,
        input decoded_op_t issue,
        input logic        wr_en,
        input reg_idx_t    wr_idx,
        input wb_t         wb
);

        // Number of assertion failures seen so far.
        int failures = 0;

        // Reset has to clear the writeback register by the following edge.
        wb_cleared_by_reset: assert property (
                @(posedge clk) reset |=> !wb.valid
        ) else begin
                $error("wb.valid set in the cycle after reset");
                failures++;
        end

        // Register x0 and illegal operations never reach the register file.
        no_bad_write: assert property (
                @(posedge clk) disable iff (reset)
                wr_en |-> ((wr_idx != '0) && !issue.illegal)
        ) else begin
                $error("register write to x0 or from an illegal operation");
                failures++;
        end

        issue_reaches_wb: assert property (
                @(posedge clk) disable iff (reset)
                issue.valid |=> wb.valid
        ) else begin
                $error("issued operation did not reach writeback on the next cycle");
                failures++;
        end

endmodule

bind writeback_stage exec_unit_props exec_unit_props_inst (
        .clk    (clk),
        .reset  (reset),
        .issue  (issue),
        .wr_en  (wr_en),
        .wr_idx (wr_idx),
        .wb     (wb)
);

/* rtl/exec_unit_top.sv */
module exec_unit_top
        import rv32_isa_pkg::*;
        import exec_pkg::*;
(
        input  logic     clk,
        input  logic     reset,
        input  logic     instr_valid,
        input  instr_t   instr,
        output logic     wb_valid,
        output logic     wb_illegal,
        output reg_idx_t wb_rd,
        output data_t    wb_data,
        output logic     wb_zero
);

        decoded_op_t issue;
        wb_t         wb;
        reg_idx_t    rs1_idx;
        reg_idx_t    rs2_idx;
        data_t       rs1_data;
        data_t       rs2_data;
        data_t       result;
        logic        zero;
        logic        wr_en;
        reg_idx_t    wr_idx;
        data_t       wr_data;

        instr_decoder instr_decoder_inst (
                .clk         (clk),
                .reset       (reset),
                .instr_valid (instr_valid),
                .instr       (instr),
                .rs1_data    (rs1_data),
                .rs2_data    (rs2_data),
                .fwd_data    (result),
                .rs1_idx     (rs1_idx),
                .rs2_idx     (rs2_idx),
                .issue       (issue)
        );

        register_file register_file_inst (
                .clk      (clk),
                .reset    (reset),
                .rs1_idx  (rs1_idx),
                .rs2_idx  (rs2_idx),
                .wr_en    (wr_en),
                .wr_idx   (wr_idx),
                .wr_data  (wr_data),
                .rs1_data (rs1_data),
                .rs2_data (rs2_data)
        );

        alu alu_inst (
                .alu_op    (issue.alu_op),
                .operand_a (issue.operand_a),
                .operand_b (issue.operand_b),
                .result    (result),
                .zero      (zero)
        );

        writeback_stage writeback_stage_inst (
                .clk     (clk),
                .reset   (reset),
                .issue   (issue),
                .result  (result),
                .zero    (zero),
                .wr_en   (wr_en),
                .wr_idx  (wr_idx),
                .wr_data (wr_data),
                .wb      (wb)
        );

        assign wb_valid   = wb.valid;
        assign wb_illegal = wb.illegal;
        assign wb_rd      = wb.rd;
        assign wb_data    = wb.data;
        assign wb_zero    = wb.zero;

endmodule

/* rtl/writeback_stage.sv */
module writeback_stage
        import exec_pkg::*;
(
        input  logic        clk,
        input  logic        reset,
        input  decoded_op_t issue,
        input  data_t       result,
        input  logic        zero,
        output logic        wr_en,
        output reg_idx_t    wr_idx,
        output data_t       wr_data,
        output wb_t         wb
);

        // The register file takes the result at the same edge as the wb register.
        assign wr_en   = issue.valid && issue.write_en;
        assign wr_idx  = issue.rd;
        assign wr_data = result;

        always_ff @(posedge clk) begin
                wb.rd   <= issue.rd;
                wb.data <= result;
                wb.zero <= zero;
                if (reset) begin
                        wb.valid   <= 1'b0;
                        wb.illegal <= 1'b0;
                end else begin
                        wb.valid   <= issue.valid;
                        wb.illegal <= issue.valid && issue.illegal;
                end
        end

endmodule

/* rtl/instr_decoder.sv */
module instr_decoder
        import rv32_isa_pkg::*;
        import exec_pkg::*;
(
        input  logic        clk,
        input  logic        reset,
        input  logic        instr_valid,
        input  instr_t      instr,
        input  data_t       rs1_data,
        input  data_t       rs2_data,
        input  data_t       fwd_data,
        output reg_idx_t    rs1_idx,
        output reg_idx_t    rs2_idx,
        output decoded_op_t issue
);

        opcode_t  opcode;
        funct3_t  funct3;
        funct7_t  funct7;
        reg_idx_t rd;
        data_t    imm_i;
        data_t    imm_u;
        data_t    shamt_ext;
        data_t    rs1_val;
        data_t    rs2_val;
        data_t    operand_b;
        alu_op_t  alu_op;
        logic     illegal;
        logic     fwd_rs1;
        logic     fwd_rs2;

        assign opcode  = instr[6:0];
        assign rd      = instr[11:7];
        assign funct3  = instr[14:12];
        assign rs1_idx = instr[19:15];
        assign rs2_idx = instr[24:20];
        assign funct7  = instr[31:25];

        assign imm_i     = {{20{instr[31]}}, instr[31:20]};
        assign imm_u     = {instr[31:12], 12'h000};
        assign shamt_ext = {27'd0, shamt_t'(instr[24:20])};

        // The instruction in issue writes the register file only at the next edge,
        // so its result has to be taken straight from the ALU.
        assign fwd_rs1 = issue.valid && issue.write_en && (issue.rd == rs1_idx) && (rs1_idx != '0);
        assign fwd_rs2 = issue.valid && issue.write_en && (issue.rd == rs2_idx) && (rs2_idx != '0);
        assign rs1_val = fwd_rs1 ? fwd_data : rs1_data;
        assign rs2_val = fwd_rs2 ? fwd_data : rs2_data;

        always_comb begin
                alu_op    = ALU_ADD;
                illegal   = 1'b0;
                operand_b = rs2_val;
                case (opcode)
                        OPCODE_OP: begin
                                case (funct3)
                                        F3_ADD_SUB: alu_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                                        F3_SLL:     alu_op = ALU_SLL;
                                        F3_SLT:     alu_op = ALU_SLT;
                                        F3_SLTU:    alu_op = ALU_SLTU;
                                        F3_XOR:     alu_op = ALU_XOR;
                                        F3_SRL_SRA: alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                                        F3_OR:      alu_op = ALU_OR;
                                        F3_AND:     alu_op = ALU_AND;
                                endcase
                                // Only ADD/SUB and SRL/SRA accept the alternate funct7.
                                if (funct7 != F7_BASE) begin
                                        illegal = !((funct7 == F7_ALT) &&
                                                ((funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA)));
                                end
                        end
                        OPCODE_OP_IMM: begin
                                operand_b = imm_i;
                                case (funct3)
                                        F3_ADD_SUB: alu_op = ALU_ADD;
                                        F3_SLT:     alu_op = ALU_SLT;
                                        F3_SLTU:    alu_op = ALU_SLTU;
                                        F3_XOR:     alu_op = ALU_XOR;
                                        F3_OR:      alu_op = ALU_OR;
                                        F3_AND:     alu_op = ALU_AND;
                                        F3_SLL: begin
                                                alu_op    = ALU_SLL;
                                                operand_b = shamt_ext;
                                                illegal   = (funct7 != F7_BASE);
                                        end
                                        F3_SRL_SRA: begin
                                                alu_op    = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                                                operand_b = shamt_ext;
                                                illegal   = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                                        end
                                endcase
                        end
                        OPCODE_LUI: begin
                                alu_op    = ALU_PASS_B;
                                operand_b = imm_u;
                        end
                        default: illegal = 1'b1;
                endcase
        end

        always_ff @(posedge clk) begin
                issue.alu_op    <= alu_op;
                issue.operand_a <= rs1_val;
                issue.operand_b <= operand_b;
                issue.rd        <= rd;
                if (reset) begin
                        issue.valid    <= 1'b0;
                        issue.illegal  <= 1'b0;
                        issue.write_en <= 1'b0;
                end else begin
                        issue.valid    <= instr_valid;
                        issue.illegal  <= instr_valid && illegal;
                        issue.write_en <= instr_valid && !illegal && (rd != '0);
                end
        end

endmodule

/* rtl/alu.sv */
module alu
        import exec_pkg::*;
(
        input  alu_op_t alu_op,
        input  data_t   operand_a,
        input  data_t   operand_b,
        output data_t   result,
        output logic    zero
);

        shamt_t shamt;
        logic   slt_result;
        logic   sltu_result;

        // Shifts use only the low five bits of operand B.
        assign shamt = operand_b[4:0];

        assign slt_result  = $signed(operand_a) < $signed(operand_b);
        assign sltu_result = operand_a < operand_b;

        always_comb begin
                case (alu_op)
                        ALU_ADD:    result = operand_a + operand_b;
                        ALU_SUB:    result = operand_a - operand_b;
                        ALU_SLL:    result = operand_a << shamt;
                        ALU_SLT:    result = {31'd0, slt_result};
                        ALU_SLTU:   result = {31'd0, sltu_result};
                        ALU_XOR:    result = operand_a ^ operand_b;
                        ALU_SRL:    result = operand_a >> shamt;
                        ALU_SRA:    result = data_t'($signed(operand_a) >>> shamt);
                        ALU_OR:     result = operand_a | operand_b;
                        ALU_AND:    result = operand_a & operand_b;
                        ALU_PASS_B: result = operand_b;
                        default:    result = '0;
                endcase
        end

        assign zero = (result == '0);

endmodule

/* rtl/register_file.sv */
module register_file
        import exec_pkg::*;
(
        input  logic     clk,
        input  logic     reset,
        input  reg_idx_t rs1_idx,
        input  reg_idx_t rs2_idx,
        input  logic     wr_en,
        input  reg_idx_t wr_idx,
        input  data_t    wr_data,
        output data_t    rs1_data,
        output data_t    rs2_data
);

        // Register x0 has no storage and always reads as zero.
        data_t regs [1:NUM_REGS-1];

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 1; i < NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wr_en && (wr_idx != '0)) begin
                        regs[wr_idx] <= wr_data;
                end
        end

        // Reads see the value before any write in the same cycle.
        assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
        assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

/* rtl/exec_pkg.sv */
package exec_pkg;

        localparam int XLEN     = 32;
        localparam int NUM_REGS = 32;

        typedef logic [XLEN-1:0] data_t;
        typedef logic [4:0]      reg_idx_t;
        typedef logic [4:0]      shamt_t;

        typedef enum logic [3:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_SLL,
                ALU_SLT,
                ALU_SLTU,
                ALU_XOR,
                ALU_SRL,
                ALU_SRA,
                ALU_OR,
                ALU_AND,
                ALU_PASS_B
        } alu_op_t;

        // Operation held in the issue register while the ALU works on it.
        typedef struct packed {
                logic     valid;
                logic     illegal;
                alu_op_t  alu_op;
                data_t    operand_a;
                data_t    operand_b;
                reg_idx_t rd;
                logic     write_en;
        } decoded_op_t;

        typedef struct packed {
                logic     valid;
                logic     illegal;
                reg_idx_t rd;
                data_t    data;
                logic     zero;
        } wb_t;

endpackage

/* rtl/rv32_isa_pkg.sv */
package rv32_isa_pkg;

        // Field types of a 32-bit RV32I instruction word.
        typedef logic [31:0] instr_t;
        typedef logic [6:0]  opcode_t;
        typedef logic [2:0]  funct3_t;
        typedef logic [6:0]  funct7_t;

        // Major opcodes handled by the execute unit.
        localparam opcode_t OPCODE_OP     = 7'b0110011;
        localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
        localparam opcode_t OPCODE_LUI    = 7'b0110111;

        // The funct3 encodings are shared by the register and immediate forms.
        localparam funct3_t F3_ADD_SUB = 3'b000;
        localparam funct3_t F3_SLL     = 3'b001;
        localparam funct3_t F3_SLT     = 3'b010;
        localparam funct3_t F3_SLTU    = 3'b011;
        localparam funct3_t F3_XOR     = 3'b100;
        localparam funct3_t F3_SRL_SRA = 3'b101;
        localparam funct3_t F3_OR      = 3'b110;
        localparam funct3_t F3_AND     = 3'b111;

        // F7_ALT turns ADD into SUB and a logical right shift into an arithmetic one.
        localparam funct7_t F7_BASE = 7'b0000000;
        localparam funct7_t F7_ALT  = 7'b0100000;

endpackage
